// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN  = 64;
    localparam int ALU_W = 4;

    // ----------------------------------------
    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // funct3, alu group
    localparam logic [2:0] f3_add  = 3'b000;    // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    // funct3, branch group
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    // ----------------------------------------
    // alu ops
    localparam logic [ALU_W-1:0] alu_add    = 4'd0;
    localparam logic [ALU_W-1:0] alu_sub    = 4'd1;
    localparam logic [ALU_W-1:0] alu_and    = 4'd2;
    localparam logic [ALU_W-1:0] alu_or     = 4'd3;
    localparam logic [ALU_W-1:0] alu_xor    = 4'd4;
    localparam logic [ALU_W-1:0] alu_sll    = 4'd5;
    localparam logic [ALU_W-1:0] alu_srl    = 4'd6;
    localparam logic [ALU_W-1:0] alu_slt    = 4'd7;
    localparam logic [ALU_W-1:0] alu_pass_b = 4'd8;

    // branch conditions
    localparam logic [2:0] br_none = 3'd0;
    localparam logic [2:0] br_eq   = 3'd1;
    localparam logic [2:0] br_ne   = 3'd2;
    localparam logic [2:0] br_lt   = 3'd3;
    localparam logic [2:0] br_ge   = 3'd4;
    localparam logic [2:0] br_jal  = 3'd5;
    localparam logic [2:0] br_jalr = 3'd6;

    // operand selectors
    localparam logic [1:0] sel_a_reg  = 2'd0;
    localparam logic [1:0] sel_a_pc   = 2'd1;
    localparam logic [1:0] sel_a_zero = 2'd2;
    localparam logic       sel_b_reg  = 1'b0;
    localparam logic       sel_b_imm  = 1'b1;

    // ----------------------------------------
    // instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv_inst_t;

    localparam logic [31:0] NOP_INST = 32'h00000013;  // addi x0,x0,0

endpackage

// ==== verilog/rv_pipe_if.sv ====
`timescale 1ns/1ps

// fetch -> decode
interface fs_ds_if;
    import rv_pkg::*;

    logic            valid;
    logic            allowin;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;

    modport fs (output valid, pc, inst, input allowin);
    modport ds (input valid, pc, inst, output allowin);
endinterface

// decode -> execute, decoded bundle
interface ds_es_if;
    import rv_pkg::*;

    logic             valid;
    logic             allowin;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  src1;
    logic [XLEN-1:0]  src2;
    logic [XLEN-1:0]  imm;
    logic [4:0]       rd;
    logic [ALU_W-1:0] alu_op;
    logic [1:0]       a_sel;
    logic             b_sel;
    logic [2:0]       br_cond;
    logic             reg_wen;

    modport ds (output valid, pc, src1, src2, imm, rd, alu_op, a_sel, b_sel, br_cond,
                reg_wen, input allowin);
    modport es (input valid, pc, src1, src2, imm, rd, alu_op, a_sel, b_sel, br_cond,
                reg_wen, output allowin);
endinterface

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              raddr1_i,
    input  logic [4:0]              raddr2_i,
    output logic [rv_pkg::XLEN-1:0] rdata1_o,
    output logic [rv_pkg::XLEN-1:0] rdata2_o,
    input  logic                    wen_i,
    input  logic [4:0]              waddr_i,
    input  logic [rv_pkg::XLEN-1:0] wdata_i
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];
    logic            wr_live;     // write that actually lands

    assign wr_live = wen_i && (waddr_i != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle bypass
    assign rdata1_o = (wr_live && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (wr_live && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// ==== verilog/rv_fetch_stage.sv ====
`timescale 1ns/1ps

module rv_fetch_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic [rv_pkg::XLEN-1:0] target_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [31:0]             imem_data_i,
    fs_ds_if.fs                     out
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic            fs_valid;    // set once reset is released

    always_ff @(posedge clk) begin
        if (rst) begin
            fs_valid <= 1'b0;
        end else begin
            fs_valid <= 1'b1;
        end
    end

    // ----------------------------------------
    // pc update
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (flush_i) begin
            pc <= target_i;              // redirect wins over advance
        end else if (out.valid && out.allowin) begin
            pc <= pc + XLEN'(4);
        end
    end

    assign imem_addr_o = pc;

    // word fetched under a flush is from the wrong path
    assign out.valid = fs_valid && !flush_i;
    assign out.pc    = pc;
    assign out.inst  = imem_data_i;

endmodule

// ==== verilog/rv_decode_stage.sv ====
`timescale 1ns/1ps

module rv_decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    fs_ds_if.ds                     in,
    ds_es_if.ds                     out,
    input  logic                    flush_i,
    input  logic                    rf_wen_i,
    input  logic [4:0]              rf_waddr_i,
    input  logic [rv_pkg::XLEN-1:0] rf_wdata_i
);
    import rv_pkg::*;

    logic            ds_valid;
    logic [XLEN-1:0] ds_pc;
    rv_inst_t        ds_inst;
    rv_inst_t        inst;
    logic [XLEN-1:0] imm_i, imm_b, imm_u, imm_j;

    // ----------------------------------------
    // buffer, one entry
    assign in.allowin = !ds_valid || out.allowin;
    assign out.valid  = ds_valid;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            ds_valid <= 1'b0;
        end else if (in.allowin) begin
            ds_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            ds_pc   <= in.pc;
            ds_inst <= in.inst;
        end
    end

    assign inst = ds_valid ? ds_inst : rv_inst_t'(NOP_INST);  // empty slot decodes as nop

    // ----------------------------------------
    // immediates per format
    assign imm_i = {{52{inst.i.imm[11]}}, inst.i.imm};
    assign imm_b = {{51{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                    inst.b.imm4_1, 1'b0};
    assign imm_u = {{32{inst.u.imm[19]}}, inst.u.imm, 12'b0};
    assign imm_j = {{43{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                    inst.j.imm10_1, 1'b0};

    always_comb begin
        out.alu_op  = alu_add;           // bubble unless matched below
        out.a_sel   = sel_a_reg;
        out.b_sel   = sel_b_reg;
        out.br_cond = br_none;
        out.reg_wen = 1'b0;
        out.imm     = '0;
        case (inst.r.opcode)
            op_lui: begin
                {out.alu_op, out.a_sel, out.b_sel} = {alu_pass_b, sel_a_zero, sel_b_imm};
                out.imm     = imm_u;
                out.reg_wen = 1'b1;
            end
            op_auipc: begin
                {out.a_sel, out.b_sel} = {sel_a_pc, sel_b_imm};
                out.imm     = imm_u;
                out.reg_wen = 1'b1;
            end
            op_jal: begin
                out.br_cond = br_jal;
                out.imm     = imm_j;
                out.reg_wen = 1'b1;
            end
            op_jalr: begin
                if (inst.i.funct3 == f3_jalr) begin
                    out.br_cond = br_jalr;
                    out.imm     = imm_i;
                    out.reg_wen = 1'b1;
                end
            end
            op_branch: begin
                out.imm = imm_b;
                case (inst.b.funct3)
                    f3_beq:  out.br_cond = br_eq;
                    f3_bne:  out.br_cond = br_ne;
                    f3_blt:  out.br_cond = br_lt;
                    f3_bge:  out.br_cond = br_ge;
                    default: out.br_cond = br_none;  // bltu/bgeu unsupported
                endcase
            end
            op_imm: begin
                out.b_sel   = sel_b_imm;
                out.imm     = imm_i;
                out.reg_wen = 1'b1;
                case (inst.i.funct3)
                    f3_add: out.alu_op = alu_add;
                    f3_slt: out.alu_op = alu_slt;
                    f3_and: out.alu_op = alu_and;
                    f3_or:  out.alu_op = alu_or;
                    f3_xor: out.alu_op = alu_xor;
                    f3_sll: out.alu_op = alu_sll;
                    f3_srl: begin
                        out.alu_op  = alu_srl;
                        out.reg_wen = (inst.r.funct7[6:1] == 6'b0);  // srai not supported
                    end
                    default: out.reg_wen = 1'b0;
                endcase
                if (inst.i.funct3 == f3_sll && inst.r.funct7[6:1] != 6'b0) begin
                    out.reg_wen = 1'b0;
                end
            end
            op_reg: begin
                out.reg_wen = (inst.r.funct7 == 7'b0);
                case (inst.r.funct3)
                    f3_add: begin
                        out.alu_op  = (inst.r.funct7 == funct7_sub) ? alu_sub : alu_add;
                        out.reg_wen = (inst.r.funct7 == 7'b0) || (inst.r.funct7 == funct7_sub);
                    end
                    f3_and:  out.alu_op = alu_and;
                    f3_or:   out.alu_op = alu_or;
                    f3_xor:  out.alu_op = alu_xor;
                    f3_sll:  out.alu_op = alu_sll;
                    f3_srl:  out.alu_op = alu_srl;
                    f3_slt:  out.alu_op = alu_slt;
                    default: out.reg_wen = 1'b0;   // sltu
                endcase
            end
            default: ;
        endcase
    end

    assign out.pc = ds_pc;
    assign out.rd = inst.r.rd;

    // operands read in the cycle of transfer, write-through covers the retiring result
    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (inst.r.rs1),
        .raddr2_i (inst.r.rs2),
        .rdata1_o (out.src1),
        .rdata2_o (out.src2),
        .wen_i    (rf_wen_i),
        .waddr_i  (rf_waddr_i),
        .wdata_i  (rf_wdata_i)
    );

endmodule

// ==== verilog/rv_execute_stage.sv ====
`timescale 1ns/1ps

module rv_execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    ds_es_if.es                     in,
    input  logic                    retire_ready_i,
    output logic                    retire_valid_o,
    output logic [rv_pkg::XLEN-1:0] retire_pc_o,
    output logic [4:0]              retire_rd_o,
    output logic                    retire_wen_o,
    output logic [rv_pkg::XLEN-1:0] retire_data_o,
    output logic                    flush_o,
    output logic [rv_pkg::XLEN-1:0] target_o,
    output logic                    rf_wen_o,
    output logic [4:0]              rf_waddr_o,
    output logic [rv_pkg::XLEN-1:0] rf_wdata_o
);
    import rv_pkg::*;

    logic             es_valid;
    logic [XLEN-1:0]  es_pc, es_src1, es_src2, es_imm;
    logic [4:0]       es_rd;
    logic [ALU_W-1:0] es_alu_op;
    logic [1:0]       es_a_sel;
    logic             es_b_sel;
    logic [2:0]       es_br_cond;
    logic             es_reg_wen;
    logic [XLEN-1:0]  alu_a, alu_b, alu_res, result, jalr_sum;
    logic             taken, retire, es_wen;

    assign in.allowin = !es_valid || retire_ready_i;
    assign retire     = es_valid && retire_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (in.allowin) begin
            es_valid <= in.valid && !flush_o;   // younger word dies on redirect
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            {es_pc, es_src1, es_src2, es_imm, es_rd} <= {in.pc, in.src1, in.src2, in.imm, in.rd};
            {es_alu_op, es_a_sel, es_b_sel}          <= {in.alu_op, in.a_sel, in.b_sel};
            {es_br_cond, es_reg_wen}                 <= {in.br_cond, in.reg_wen};
        end
    end

    // ----------------------------------------
    // alu
    always_comb begin
        case (es_a_sel)
            sel_a_pc:   alu_a = es_pc;
            sel_a_zero: alu_a = '0;
            default:    alu_a = es_src1;
        endcase
        alu_b = (es_b_sel == sel_b_imm) ? es_imm : es_src2;
        case (es_alu_op)
            alu_sub:    alu_res = alu_a - alu_b;
            alu_and:    alu_res = alu_a & alu_b;
            alu_or:     alu_res = alu_a | alu_b;
            alu_xor:    alu_res = alu_a ^ alu_b;
            alu_sll:    alu_res = alu_a << alu_b[5:0];
            alu_srl:    alu_res = alu_a >> alu_b[5:0];
            alu_slt:    alu_res = XLEN'($signed(alu_a) < $signed(alu_b));
            alu_pass_b: alu_res = alu_b;
            default:    alu_res = alu_a + alu_b;
        endcase
    end

    // ----------------------------------------
    // branch resolution
    always_comb begin
        case (es_br_cond)
            br_eq:           taken = (es_src1 == es_src2);
            br_ne:           taken = (es_src1 != es_src2);
            br_lt:           taken = ($signed(es_src1) < $signed(es_src2));
            br_ge:           taken = ($signed(es_src1) >= $signed(es_src2));
            br_jal, br_jalr: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum = es_src1 + es_imm;
    assign target_o = (es_br_cond == br_jalr) ? {jalr_sum[XLEN-1:1], 1'b0} : es_pc + es_imm;
    assign result   = (es_br_cond == br_jal || es_br_cond == br_jalr) ? es_pc + XLEN'(4)
                                                                      : alu_res;
    assign es_wen   = es_reg_wen && (es_rd != 5'd0);
    assign flush_o  = retire && taken;

    // retire report
    assign retire_valid_o = es_valid;
    assign retire_pc_o    = es_pc;
    assign retire_rd_o    = es_rd;
    assign retire_wen_o   = es_wen;
    assign retire_data_o  = result;

    // writeback, only on retire
    assign rf_wen_o   = retire && es_wen;
    assign rf_waddr_o = es_rd;
    assign rf_wdata_o = result;

endmodule

// ==== verilog/rv_pipe_top.sv ====
`timescale 1ns/1ps

module rv_pipe_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [31:0]             imem_data_i,
    input  logic                    retire_ready_i,
    output logic                    retire_valid_o,
    output logic [rv_pkg::XLEN-1:0] retire_pc_o,
    output logic [4:0]              retire_rd_o,
    output logic                    retire_wen_o,
    output logic [rv_pkg::XLEN-1:0] retire_data_o
);
    import rv_pkg::*;

    logic            flush;
    logic [XLEN-1:0] target;
    logic            rf_wen;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    fs_ds_if fs_ds ();
    ds_es_if ds_es ();

    rv_fetch_stage #(
        .RESET_PC (RESET_PC)
    ) rv_fetch_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush),
        .target_i    (target),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .out         (fs_ds.fs)
    );

    rv_decode_stage rv_decode_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .in         (fs_ds.ds),
        .out        (ds_es.ds),
        .flush_i    (flush),
        .rf_wen_i   (rf_wen),
        .rf_waddr_i (rf_waddr),
        .rf_wdata_i (rf_wdata)
    );

    rv_execute_stage rv_execute_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .in             (ds_es.es),
        .retire_ready_i (retire_ready_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wen_o   (retire_wen_o),
        .retire_data_o  (retire_data_o),
        .flush_o        (flush),
        .target_o       (target),
        .rf_wen_o       (rf_wen),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata)
    );

endmodule

// ==== testbench/tb_rv_pipe.sv ====
`timescale 1ns/1ps

module tb_rv_pipe;
    import rv_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam int MAX_WORDS = 64;
    localparam int N_RAND    = 16;
    localparam int TIMEOUT   = 200;

    logic            clk;
    logic            rst = 1'b1;
    logic [XLEN-1:0] imem_addr;
    logic [31:0]     imem_data;
    logic            retire_ready = 1'b0;
    logic            retire_valid;
    logic [XLEN-1:0] retire_pc;
    logic [4:0]      retire_rd;
    logic            retire_wen;
    logic [XLEN-1:0] retire_data;

    logic [31:0]     prog [MAX_WORDS];
    int              prog_len = 0;
    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_pc;
    integer          seed = 67;
    logic            stall_mode = 1'b0;

    rv_pipe_top #(
        .RESET_PC (RESET_PC)
    ) rv_pipe_top_inst (
        .clk            (clk),
        .rst            (rst),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_ready_i (retire_ready),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_wen_o   (retire_wen),
        .retire_data_o  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // instruction memory, nop past the program
    function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < XLEN'(prog_len)) begin
            return prog[addr[7:2]];
        end else begin
            return NOP_INST;
        end
    endfunction

    always_comb imem_data = fetch_word(imem_addr);

    always @(posedge clk) begin
        if (stall_mode) begin
            retire_ready <= (($random(seed) & 3) != 0);   // ready about 3 cycles in 4
        end else begin
            retire_ready <= 1'b1;
        end
    end

    // ----------------------------------------
    // encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // ----------------------------------------
    // ISA model, one instruction per call
    function automatic void ref_step(output logic [XLEN-1:0] pc_o, output logic [4:0] rd_o,
                                     output logic wen_o, output logic [XLEN-1:0] data_o);
        rv_inst_t        inst;
        logic [XLEN-1:0] a, b, opb, imm_i, imm_u, imm_b, imm_j, next_pc, data;
        logic            wen, alt, take;
        inst    = fetch_word(model_pc);
        a       = model_regs[inst.r.rs1];
        b       = model_regs[inst.r.rs2];
        imm_i   = XLEN'($signed(inst.i.imm));
        imm_u   = XLEN'($signed({inst.u.imm, 12'h000}));
        imm_b   = XLEN'($signed({inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                                 inst.b.imm4_1, 1'b0}));
        imm_j   = XLEN'($signed({inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                                 inst.j.imm10_1, 1'b0}));
        next_pc = model_pc + 64'd4;
        data    = '0;
        wen     = 1'b0;
        take    = 1'b0;
        alt     = (inst.r.funct7 == funct7_sub);
        case (inst.r.opcode)
            op_lui: begin
                wen  = 1'b1;
                data = imm_u;
            end
            op_auipc: begin
                wen  = 1'b1;
                data = model_pc + imm_u;
            end
            op_jal: begin
                wen     = 1'b1;
                data    = model_pc + 64'd4;
                next_pc = model_pc + imm_j;
            end
            op_jalr: begin
                if (inst.i.funct3 == 3'b000) begin
                    wen     = 1'b1;
                    data    = model_pc + 64'd4;
                    next_pc = (a + imm_i) & ~64'd1;
                end
            end
            op_branch: begin
                case (inst.b.funct3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next_pc = model_pc + imm_b;
                end
            end
            op_imm, op_reg: begin
                opb = (inst.r.opcode == op_imm) ? imm_i : b;
                wen = 1'b1;
                case (inst.r.funct3)
                    3'b000:  data = (inst.r.opcode == op_reg && alt) ? a - opb : a + opb;
                    3'b001:  data = a << opb[5:0];
                    3'b010:  data = {63'd0, $signed(a) < $signed(opb)};
                    3'b100:  data = a ^ opb;
                    3'b101:  data = a >> opb[5:0];
                    3'b110:  data = a | opb;
                    3'b111:  data = a & opb;
                    default: wen = 1'b0;    // sltu
                endcase
                // encodings outside the subset: sra, srai, odd funct7
                if (inst.r.opcode == op_reg && inst.r.funct7 != 7'd0
                        && !(alt && inst.r.funct3 == 3'b000)) begin
                    wen = 1'b0;
                end
                if (inst.r.opcode == op_imm && inst.r.funct7[6:1] != 6'd0
                        && (inst.r.funct3 == 3'b001 || inst.r.funct3 == 3'b101)) begin
                    wen = 1'b0;
                end
            end
            default: ;
        endcase
        wen = wen && (inst.r.rd != 5'd0);
        if (wen) begin
            model_regs[inst.r.rd] = data;
        end
        pc_o     = model_pc;
        rd_o     = inst.r.rd;
        wen_o    = wen;
        data_o   = data;
        model_pc = next_pc;
    endfunction

    // ----------------------------------------
    // program
    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] shadow;
        logic [31:0] word;
        integer      r;
        int          pick;
        shadow = enc_i(12'd99, 0, f3_add, 20, op_imm);  // must never retire
        emit(enc_i(12'd5, 0, f3_add, 1, op_imm));
        emit(enc_i(12'hffd, 1, f3_add, 2, op_imm));     // uses x1 right away
        emit(enc_r(7'd0, 2, 1, f3_add, 3));
        emit(enc_r(funct7_sub, 3, 2, f3_add, 4));        // x4 = -5
        emit(enc_r(7'd0, 1, 4, f3_slt, 5));
        emit(enc_i(12'hff6, 4, f3_slt, 6, op_imm));
        emit(enc_i(12'h0f0, 4, f3_xor, 7, op_imm));
        emit(enc_i(12'h700, 1, f3_or, 8, op_imm));
        emit(enc_i(12'h7ff, 4, f3_and, 9, op_imm));
        emit(enc_i(12'd40, 4, f3_sll, 10, op_imm));      // shamt above 31
        emit(enc_i(12'd33, 10, f3_srl, 11, op_imm));
        emit(enc_r(7'd0, 2, 1, f3_sll, 12));
        emit(enc_r(7'd0, 1, 4, f3_srl, 13));
        emit(enc_r(7'd0, 8, 4, f3_and, 14));
        emit(enc_r(7'd0, 2, 7, f3_or, 15));
        emit(enc_r(7'd0, 14, 15, f3_xor, 16));
        emit(enc_i(12'd7, 1, f3_add, 0, op_imm));        // x0 target
        emit(enc_r(7'd0, 1, 0, f3_add, 17));
        emit(enc_u(20'h80001, 18, op_lui));
        emit(enc_u(20'h12345, 19, op_auipc));
        emit(enc_b(13'd8, 1, 1, f3_beq));
        emit(shadow);
        emit(enc_b(13'd8, 2, 1, f3_bne));
        emit(shadow);
        emit(enc_b(13'd8, 1, 4, f3_blt));                // -5 < 5
        emit(shadow);
        emit(enc_b(13'd8, 4, 1, f3_bge));
        emit(shadow);
        emit(enc_b(13'd8, 2, 1, f3_beq));                // fall-through group
        emit(enc_b(13'd8, 1, 1, f3_bne));
        emit(enc_b(13'd8, 4, 1, f3_blt));
        emit(enc_b(13'd8, 1, 4, f3_bge));
        emit(enc_j(21'd12, 21));
        repeat (2) emit(shadow);
        emit(enc_u(20'h0, 22, op_auipc));
        emit(enc_i(12'd21, 22, f3_jalr, 23, op_jalr));  // odd sum, bit 0 dropped
        repeat (3) emit(shadow);
        emit(32'hffff_ffff);
        emit(32'h0000_0000);
        emit(enc_r(7'd0, 2, 1, 3'b011, 25));            // sltu is not supported
        for (int k = 0; k < N_RAND; k++) begin
            r    = $random(seed);
            pick = $unsigned($random(seed)) % 10;
            case (pick)
                0:       word = enc_i(r[26:15], r[9:5], f3_add, r[4:0], op_imm);
                1:       word = enc_i(r[26:15], r[9:5], f3_slt, r[4:0], op_imm);
                2:       word = enc_i(r[26:15], r[9:5], f3_xor, r[4:0], op_imm);
                3:       word = enc_i(r[26:15], r[9:5], f3_or, r[4:0], op_imm);
                4:       word = enc_i(r[26:15], r[9:5], f3_and, r[4:0], op_imm);
                5:       word = enc_r(7'd0, r[14:10], r[9:5], f3_add, r[4:0]);
                6:       word = enc_r(funct7_sub, r[14:10], r[9:5], f3_add, r[4:0]);
                7:       word = enc_r(7'd0, r[14:10], r[9:5], f3_slt, r[4:0]);
                8:       word = enc_r(7'd0, r[14:10], r[9:5], f3_sll, r[4:0]);
                default: word = enc_r(7'd0, r[14:10], r[9:5], f3_srl, r[4:0]);
            endcase
            emit(word);
        end
    endtask

    // ----------------------------------------
    // checking
    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // returns at the negedge before the edge that retires
    task automatic wait_retire(output int waited);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(retire_valid && retire_ready) && cycles < TIMEOUT);
        if (!(retire_valid && retire_ready)) begin
            $display("timeout: nothing retired for %0d cycles at time %0t", TIMEOUT, $time);
            $display("Regression failed");
            $fatal(1);
        end
        waited = cycles;
    endtask

    task automatic run_program();
        logic [XLEN-1:0] exp_pc, exp_data, prev_pc;
        logic [4:0]      exp_rd;
        logic            exp_wen, have_prev;
        int              waited;
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc  = RESET_PC;
        prev_pc   = '0;
        have_prev = 1'b0;
        while (model_pc < XLEN'(prog_len * 4)) begin
            wait_retire(waited);
            ref_step(exp_pc, exp_rd, exp_wen, exp_data);
            check_value("retire_pc_o", retire_pc, exp_pc);
            // at full rate a sequential successor retires on the very next edge
            if (!stall_mode && have_prev && exp_pc == prev_pc + 64'd4) begin
                assert (waited == 1) else begin
                    $display("stall: pc %h retired %0d cycles after the one before it, time %0t",
                             exp_pc, waited, $time);
                    $display("Regression failed");
                    $fatal(1);
                end
            end
            prev_pc   = exp_pc;
            have_prev = 1'b1;
            check_value("retire_wen_o", XLEN'(retire_wen), XLEN'(exp_wen));
            if (exp_wen) begin
                check_value("retire_rd_o", XLEN'(retire_rd), XLEN'(exp_rd));
                check_value("retire_data_o", retire_data, exp_data);
            end
        end
    endtask

    initial begin
        build_program();
        stall_mode = 1'b0;   // full rate first
        run_program();
        stall_mode = 1'b1;   // same program under back-pressure
        run_program();
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/rv_pkg.sv
verilog/rv_pipe_if.sv
verilog/rv_regfile.sv
verilog/rv_fetch_stage.sv
verilog/rv_decode_stage.sv
verilog/rv_execute_stage.sv
verilog/rv_pipe_top.sv
testbench/tb_rv_pipe.sv
